//--- src/axi_mem_macros.svh
// Bus widths, memory geometry and size codes for the AXI SRAM subsystem
`ifndef AXI_MEM_MACROS_SVH
`define AXI_MEM_MACROS_SVH

// --------------------
// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_ID_W 4

// --------------------
// Memory geometry of 256 words by 64 bits
`define MEM_DEPTH 256
`define MEM_IDX_W 8

// AxSIZE code of a full-width beat and log2 of the bytes per word
`define AXI_FULL_SIZE 3

`endif

//--- src/axi_pkg.sv
// AXI4 protocol types and burst helpers shared by the channel controllers
`include "axi_mem_macros.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef logic [`AXI_ID_W-1:0] axi_id_t;
  typedef logic [7:0] axi_len_t;

  // Only full-width FIXED and INCR bursts are served
  function automatic resp_e burst_resp(burst_e burst, logic [2:0] size);
    logic supported;
    supported = ((burst == FIXED) || (burst == INCR)) && (size == 3'(`AXI_FULL_SIZE));
    return supported ? OKAY : SLVERR;
  endfunction

  // Byte address of the following beat
  function automatic logic [`AXI_ADDR_W-1:0] next_addr(burst_e burst,
                                                       logic [`AXI_ADDR_W-1:0] addr);
    return (burst == FIXED) ? addr : addr + `AXI_ADDR_W'(`AXI_DATA_W / 8);
  endfunction

endpackage

//--- src/mem_pkg.sv
// Memory-side types for word data, byte strobes and word indexing
`include "axi_mem_macros.svh"

package mem_pkg;

  typedef logic [`AXI_ADDR_W-1:0] mem_addr_t;
  typedef logic [`AXI_DATA_W-1:0] mem_data_t;
  typedef logic [`AXI_DATA_W/8-1:0] mem_strb_t;
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t;

  // Upper address bits are dropped, so accesses wrap modulo the depth
  function automatic mem_idx_t word_idx(mem_addr_t addr);
    return addr[`MEM_IDX_W+`AXI_FULL_SIZE-1:`AXI_FULL_SIZE];
  endfunction

endpackage

//--- src/sram_port_if.sv
// One SRAM access port between a channel controller and the memory array
`timescale 1ns/1ps

interface sram_port_if;
  import mem_pkg::*;

  logic      en;
  logic      we;
  mem_idx_t  idx;
  mem_data_t wdata;
  mem_strb_t strb;
  mem_data_t rdata;

  modport ctrl (
    output en,
    output we,
    output idx,
    output wdata,
    output strb,
    input  rdata
  );

  modport mem (
    input  en,
    input  we,
    input  idx,
    input  wdata,
    input  strb,
    output rdata
  );

endinterface

//--- src/axi_rd_ctrl.sv
// AXI4 read channel controller streaming bursts out of the SRAM read port
`timescale 1ns/1ps

module axi_rd_ctrl (
  input  logic               i_aclk,
  input  logic               i_arst_n,
  input  axi_pkg::axi_id_t   i_arid,
  input  mem_pkg::mem_addr_t i_araddr,
  input  axi_pkg::axi_len_t  i_arlen,
  input  logic [2:0]         i_arsize,
  input  axi_pkg::burst_e    i_arburst,
  input  logic               i_arvalid,
  output logic               o_arready,
  output axi_pkg::axi_id_t   o_rid,
  output mem_pkg::mem_data_t o_rdata,
  output axi_pkg::resp_e     o_rresp,
  output logic               o_rlast,
  output logic               o_rvalid,
  input  logic               i_rready,
  sram_port_if.ctrl          rd_port
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BURST
  } state_e;

  state_e    state;
  logic      ar_fire;
  logic      r_fire;
  logic      last_beat;
  burst_e    burst_q;
  axi_len_t  len_q;
  axi_len_t  beat_cnt;
  mem_addr_t addr_q;

  assign ar_fire   = i_arvalid && o_arready;
  assign r_fire    = o_rvalid && i_rready;
  assign last_beat = (beat_cnt == len_q);

  assign o_arready = (state == ST_IDLE);
  assign o_rlast   = o_rvalid && last_beat;
  assign o_rdata   = rd_port.rdata;

  // --------------------
  // Beat 0 is read at AR and each later beat at the R transfer before it
  assign rd_port.en    = ar_fire || (r_fire && !last_beat);
  assign rd_port.we    = 1'b0;
  assign rd_port.idx   = ar_fire ? word_idx(i_araddr) : word_idx(addr_q);
  assign rd_port.wdata = '0;
  assign rd_port.strb  = '0;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= ST_IDLE;
      o_rvalid <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ar_fire) begin
            state    <= ST_BURST;
            o_rvalid <= 1'b1;
            beat_cnt <= '0;
          end
        end
        ST_BURST: begin
          if (r_fire && last_beat) begin
            state    <= ST_IDLE;
            o_rvalid <= 1'b0;
          end else if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // addr_q always points at the next beat to fetch
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      o_rid   <= i_arid;
      o_rresp <= burst_resp(i_arburst, i_arsize);
      len_q   <= i_arlen;
      burst_q <= i_arburst;
      addr_q  <= next_addr(i_arburst, i_araddr);
    end else if (r_fire && !last_beat) begin
      addr_q <= next_addr(burst_q, addr_q);
    end
  end

  // --------------------
  a_r_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rlast));

  a_idle_no_rvalid: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (state == ST_IDLE) |-> !o_rvalid);

endmodule

//--- src/axi_wr_ctrl.sv
// AXI4 write channel controller forwarding write beats to the SRAM write port
`timescale 1ns/1ps

module axi_wr_ctrl (
  input  logic               i_aclk,
  input  logic               i_arst_n,
  input  axi_pkg::axi_id_t   i_awid,
  input  mem_pkg::mem_addr_t i_awaddr,
  input  axi_pkg::axi_len_t  i_awlen,
  input  logic [2:0]         i_awsize,
  input  axi_pkg::burst_e    i_awburst,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  mem_pkg::mem_data_t i_wdata,
  input  mem_pkg::mem_strb_t i_wstrb,
  input  logic               i_wlast,
  input  logic               i_wvalid,
  output logic               o_wready,
  output axi_pkg::axi_id_t   o_bid,
  output axi_pkg::resp_e     o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  sram_port_if.ctrl          wr_port
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_RESP
  } state_e;

  state_e    state;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  burst_e    burst_q;
  axi_len_t  len_q;
  axi_len_t  beat_cnt;
  mem_addr_t addr_q;

  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;
  assign b_fire  = o_bvalid && i_bready;

  assign o_awready = (state == ST_IDLE);
  assign o_wready  = (state == ST_DATA);
  assign o_bvalid  = (state == ST_RESP);

  // Unsupported bursts drain their beats without touching memory
  assign wr_port.en    = w_fire && (o_bresp == OKAY);
  assign wr_port.we    = 1'b1;
  assign wr_port.idx   = word_idx(addr_q);
  assign wr_port.wdata = i_wdata;
  assign wr_port.strb  = i_wstrb;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (aw_fire) begin
            state    <= ST_DATA;
            beat_cnt <= '0;
          end
        end
        ST_DATA: begin
          if (w_fire && i_wlast) state <= ST_RESP;
          else if (w_fire) beat_cnt <= beat_cnt + 1'b1;
        end
        ST_RESP: if (b_fire) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      o_bid   <= i_awid;
      o_bresp <= burst_resp(i_awburst, i_awsize);
      len_q   <= i_awlen;
      burst_q <= i_awburst;
      addr_q  <= i_awaddr;
    end else if (w_fire) begin
      addr_q <= next_addr(burst_q, addr_q);
    end
  end

  // --------------------
  a_wlast_pos: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    w_fire |-> (i_wlast == (beat_cnt == len_q)));

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp));

endmodule

//--- src/sram_1r1w.sv
// Byte-writable SRAM array with one write port and one registered read port
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

module sram_1r1w (
  input  logic     i_aclk,
  sram_port_if.mem rd,
  sram_port_if.mem wr
);
  import mem_pkg::*;

  mem_data_t mem_array [`MEM_DEPTH];

  // --------------------
  // Write port with per-byte enables
  always_ff @(posedge i_aclk) begin
    if (wr.en && wr.we) begin
      for (int b = 0; b < $bits(mem_strb_t); b++) begin
        if (wr.strb[b]) begin
          mem_array[wr.idx][8*b +: 8] <= wr.wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // Read port holding the last word read
  always_ff @(posedge i_aclk) begin
    if (rd.en && !rd.we) begin
      rd.rdata <= mem_array[rd.idx];
    end
  end

  // No read path on the write port
  assign wr.rdata = '0;

  a_rd_no_write: assert property (@(posedge i_aclk) rd.en |-> !rd.we);

endmodule

//--- src/axi_sram_top.sv
// AXI4 slave SRAM subsystem joining the read and write controllers to the array
`timescale 1ns/1ps

module axi_sram_top (
  input  logic               i_aclk,
  input  logic               i_arst_n,
  // Write address
  input  axi_pkg::axi_id_t   i_awid,
  input  mem_pkg::mem_addr_t i_awaddr,
  input  axi_pkg::axi_len_t  i_awlen,
  input  logic [2:0]         i_awsize,
  input  axi_pkg::burst_e    i_awburst,
  input  logic               i_awvalid,
  output logic               o_awready,
  // Write data
  input  mem_pkg::mem_data_t i_wdata,
  input  mem_pkg::mem_strb_t i_wstrb,
  input  logic               i_wlast,
  input  logic               i_wvalid,
  output logic               o_wready,
  // Write response
  output axi_pkg::axi_id_t   o_bid,
  output axi_pkg::resp_e     o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  // Read address
  input  axi_pkg::axi_id_t   i_arid,
  input  mem_pkg::mem_addr_t i_araddr,
  input  axi_pkg::axi_len_t  i_arlen,
  input  logic [2:0]         i_arsize,
  input  axi_pkg::burst_e    i_arburst,
  input  logic               i_arvalid,
  output logic               o_arready,
  // Read data
  output axi_pkg::axi_id_t   o_rid,
  output mem_pkg::mem_data_t o_rdata,
  output axi_pkg::resp_e     o_rresp,
  output logic               o_rlast,
  output logic               o_rvalid,
  input  logic               i_rready
);

  sram_port_if rd_port ();
  sram_port_if wr_port ();

  // Controller ports share the top level names
  axi_rd_ctrl u_rd_ctrl (
    .*,
    .rd_port (rd_port.ctrl)
  );

  axi_wr_ctrl u_wr_ctrl (
    .*,
    .wr_port (wr_port.ctrl)
  );

  sram_1r1w u_sram (
    .i_aclk (i_aclk),
    .rd     (rd_port.mem),
    .wr     (wr_port.mem)
  );

endmodule

//--- sim/tb_axi_sram.sv
// Random-stimulus testbench for the AXI4 SRAM subsystem with a reference memory model
`timescale 1ns/1ps
`include "axi_mem_macros.svh"

module tb_axi_sram;
  import axi_pkg::*;
  import mem_pkg::*;

  localparam int N_TRANS = 200;
  localparam int MAX_BEATS = 16;
  // Random traffic plus the full-memory preload and readback
  localparam int TIMEOUT_CYCLES = N_TRANS * (MAX_BEATS * 2 + 20) + 4 * `MEM_DEPTH;
  localparam mem_data_t FILL_BASE = 64'h0f1e_2d3c_4b5a_6978;

  logic i_aclk = 1'b0;
  logic i_arst_n;
  axi_id_t i_awid, i_arid, o_bid, o_rid;
  mem_addr_t i_awaddr, i_araddr;
  axi_len_t i_awlen, i_arlen;
  logic [2:0] i_awsize, i_arsize;
  burst_e i_awburst, i_arburst;
  logic i_awvalid, o_awready, i_wlast, i_wvalid, o_wready, o_bvalid, i_bready;
  logic i_arvalid, o_arready, o_rlast, o_rvalid, i_rready;
  mem_data_t i_wdata, o_rdata;
  mem_strb_t i_wstrb;
  resp_e o_bresp, o_rresp;

  mem_data_t model_mem [`MEM_DEPTH];
  logic [31:0] lfsr = 32'hc34e;
  int cycle_cnt = 0;

  axi_sram_top dut (.*);

  always #10 i_aclk = ~i_aclk;

  // --------------------
  // Random source
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[62:0], rand_bit()};
    return v;
  endfunction

  function automatic resp_e expected_resp(burst_e burst, logic [2:0] size);
    if ((burst == INCR || burst == FIXED) && size == 3'd3) return OKAY;
    return SLVERR;
  endfunction

  function automatic mem_addr_t step_addr(burst_e burst, mem_addr_t a);
    return (burst == FIXED) ? a : a + 32'd8;
  endfunction

  // --------------------
  // Failure reporting and compares
  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(string name, mem_data_t got, mem_data_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_resp(string name, resp_e got, resp_e exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_id(string name, axi_id_t got, axi_id_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  // --------------------
  // Bus transactions
  task automatic write_burst(axi_id_t id, mem_addr_t addr, axi_len_t len, burst_e burst,
                             logic [2:0] size, logic fill);
    resp_e exp_resp;
    mem_addr_t a;
    mem_data_t d;
    mem_strb_t s;
    logic done;
    exp_resp = expected_resp(burst, size);
    a = addr;
    i_awid <= id;
    i_awaddr <= addr;
    i_awlen <= len;
    i_awsize <= size;
    i_awburst <= burst;
    i_awvalid <= 1'b1;
    do @(posedge i_aclk); while (!o_awready);
    i_awvalid <= 1'b0;
    for (int b = 0; b <= len; b++) begin
      d = fill ? (FILL_BASE ^ {8{a[10:3]}}) : rand_bits(64);
      s = fill ? 8'hff : mem_strb_t'(rand_bits(8));
      i_wdata <= d;
      i_wstrb <= s;
      i_wlast <= (b == len);
      i_wvalid <= 1'b1;
      do @(posedge i_aclk); while (!o_wready);
      for (int k = 0; k < 8; k++)
        if (s[k] && exp_resp == OKAY) model_mem[a[10:3]][8*k +: 8] = d[8*k +: 8];
      a = step_addr(burst, a);
    end
    i_wvalid <= 1'b0;
    i_wlast <= 1'b0;
    i_bready <= rand_bit();
    done = 1'b0;
    while (!done) begin
      @(posedge i_aclk);
      done = o_bvalid && i_bready;
      if (!done) i_bready <= rand_bit();
    end
    check_id("o_bid", o_bid, id);
    check_resp("o_bresp", o_bresp, exp_resp);
    i_bready <= 1'b0;
  endtask

  task automatic read_burst(axi_id_t id, mem_addr_t addr, axi_len_t len, burst_e burst,
                            logic [2:0] size);
    resp_e exp_resp;
    mem_addr_t a;
    int beat;
    exp_resp = expected_resp(burst, size);
    a = addr;
    beat = 0;
    i_arid <= id;
    i_araddr <= addr;
    i_arlen <= len;
    i_arsize <= size;
    i_arburst <= burst;
    i_arvalid <= 1'b1;
    do @(posedge i_aclk); while (!o_arready);
    i_arvalid <= 1'b0;
    i_rready <= rand_bit();
    while (beat <= len) begin
      @(posedge i_aclk);
      if (o_rvalid && i_rready) begin
        check_id("o_rid", o_rid, id);
        check_resp("o_rresp", o_rresp, exp_resp);
        check_last("o_rlast", o_rlast, beat == len);
        if (exp_resp == OKAY) check_data("o_rdata", o_rdata, model_mem[a[10:3]]);
        a = step_addr(burst, a);
        beat++;
      end
      i_rready <= rand_bit();
    end
    i_rready <= 1'b0;
    @(posedge i_aclk);
    if (o_rvalid) fail_run("Read burst returned more beats than arlen+1");
    check_last("o_arready", o_arready, 1'b1);
  endtask

  // --------------------
  always @(posedge i_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      fail_run("Timeout: the transactions did not complete within the cycle limit");
  end

  initial begin
    logic op;
    logic [2:0] kind;
    logic [2:0] size;
    burst_e burst;
    i_arst_n <= 1'b0;
    {i_awid, i_awaddr, i_awlen, i_awsize, i_awvalid} <= '0;
    {i_wdata, i_wstrb, i_wlast, i_wvalid, i_bready} <= '0;
    {i_arid, i_araddr, i_arlen, i_arsize, i_arvalid, i_rready} <= '0;
    i_awburst <= INCR;
    i_arburst <= INCR;
    repeat (4) @(posedge i_aclk);
    i_arst_n <= 1'b1;
    @(posedge i_aclk);
    check_last("o_arready", o_arready, 1'b1);
    check_last("o_awready", o_awready, 1'b1);
    check_last("o_rvalid", o_rvalid, 1'b0);
    check_last("o_bvalid", o_bvalid, 1'b0);
    check_last("o_wready", o_wready, 1'b0);
    // Whole array gets a known pattern first
    write_burst(4'h3, '0, 8'hff, INCR, 3'd3, 1'b1);
    read_burst(4'h5, '0, 8'hff, INCR, 3'd3);
    for (int n = 0; n < N_TRANS; n++) begin
      op = rand_bit();
      kind = 3'(rand_bits(3));
      size = 3'd3;
      if (kind < 3'd4) burst = INCR;
      else if (kind < 3'd6) burst = FIXED;
      else if (kind == 3'd6) burst = rand_bit() ? RSVD : WRAP;
      else begin
        burst = INCR;
        size = 3'(rand_bits(2));
        if (size == 3'd3) size = 3'd1;
      end
      if (op)
        read_burst(axi_id_t'(rand_bits(4)), mem_addr_t'(rand_bits(32)),
                   axi_len_t'(rand_bits(4)), burst, size);
      else
        write_burst(axi_id_t'(rand_bits(4)), mem_addr_t'(rand_bits(32)),
                    axi_len_t'(rand_bits(4)), burst, size, 1'b0);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- axi_sram.f
+incdir+src
src/axi_pkg.sv
src/mem_pkg.sv
src/sram_port_if.sv
src/axi_rd_ctrl.sv
src/axi_wr_ctrl.sv
src/sram_1r1w.sv
src/axi_sram_top.sv
sim/tb_axi_sram.sv
